// ==== list.f ====
+incdir+bench
rtl/mm_pkg.sv
rtl/mm_addr_decode.sv
rtl/mm_dp_ram.sv
rtl/mm_timer.sv
rtl/mm_scratch_regs.sv
rtl/mm_ram.sv
bench/tb_mm_ram.sv

// ==== Makefile ====
# Verilator build and run of the mm_ram testbench
# pass or fail is taken from the simulation log

VERILATOR ?= verilator
TOP       ?= tb_mm_ram
FILE_LIST ?= list.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
PASS_MSG  ?= test passed
VFLAGS    ?= --binary --assert --timescale 1ns/1ps

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILE_LIST) --Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	grep -qx "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== bench/tb_mm_ram_model.svh ====
// reference model of the mm_ram memory map, included inside the testbench module
// RAM words are undefined until written, so the stimulus only reads written words
`ifndef TB_MM_RAM_MODEL_SVH
`define TB_MM_RAM_MODEL_SVH

data_t model_mem     [RAM_WORDS];
data_t model_scratch [SCRATCH_REGS];

function automatic data_t merge_bytes(data_t old_word, data_t new_word, be_t be);
  data_t result;
  result = old_word;
  for (int b = 0; b < 4; b++) begin
    if (be[b]) begin
      result[8*b +: 8] = new_word[8*b +: 8];
    end
  end
  return result;
endfunction

function automatic data_t scratch_addr(logic [3:0] idx);
  return {SCRATCH_BASE_HI, 10'd0, idx, 2'b00};
endfunction

// grant rule of the address map, status and timer take writes only
function automatic logic is_mapped(data_t addr, logic we);
  logic write_only_hit;
  write_only_hit = (addr == ADDR_TEST_STATUS) || (addr == ADDR_EXIT) ||
                   (addr == ADDR_TIMER_MASK) || (addr == ADDR_TIMER_COUNT);
  return (addr[31:16] == 16'h0000) || (addr[31:16] == SCRATCH_BASE_HI) ||
         (we && write_only_hit);
endfunction

// scratch registers take the whole word whatever the byte enables
function automatic void model_write(data_t addr, be_t be, data_t wdata);
  if (addr[31:16] == 16'h0000) begin
    model_mem[addr[RAM_ADDR_WIDTH-1:2]] = merge_bytes(model_mem[addr[RAM_ADDR_WIDTH-1:2]],
                                                      wdata, be);
  end else if (addr[31:16] == SCRATCH_BASE_HI) begin
    model_scratch[addr[5:2]] = wdata;
  end
endfunction

// expected read data from all writes made so far
function automatic data_t ref_read(data_t addr);
  if (addr[31:16] == 16'h0000) begin
    return model_mem[addr[RAM_ADDR_WIDTH-1:2]];
  end else if (addr[31:16] == SCRATCH_BASE_HI) begin
    return model_scratch[addr[5:2]];
  end
  return '0;
endfunction

// lowest word of the aligned line lands in the low bits
function automatic instr_rdata_t ref_line(ram_addr_t addr);
  logic [RAM_ADDR_WIDTH-3:0] w;
  w = {addr[RAM_ADDR_WIDTH-1:4], 2'b00};
  return {model_mem[w + 3], model_mem[w + 2], model_mem[w + 1], model_mem[w]};
endfunction

task automatic check_data(input string what, input data_t got, input data_t exp);
  if (got !== exp) begin
    $display("MISMATCH at %0t: %s is %08h, expected %08h", $time, what, got, exp);
    abort_run();
  end
endtask

task automatic check_line(input string what, input instr_rdata_t got, input instr_rdata_t exp);
  if (got !== exp) begin
    $display("MISMATCH at %0t: %s is %032h, expected %032h", $time, what, got, exp);
    abort_run();
  end
endtask

task automatic check_bit(input string what, input logic got, input logic exp);
  if (got !== exp) begin
    $display("MISMATCH at %0t: %s is %b, expected %b", $time, what, got, exp);
    abort_run();
  end
endtask

`endif

// ==== bench/tb_mm_ram.sv ====
// testbench for mm_ram with inputs changed on the falling edge
// outputs are checked 1 ns before each rising edge and the run stops at the first error
`timescale 1ns/1ps
`default_nettype none

module tb_mm_ram
  import mm_pkg::*;
();

  localparam int CLK_PERIOD    = 20;
  localparam int SEED          = 78557;
  localparam int RAM_TESTS     = 48;
  localparam int LINE_TESTS    = 8;
  localparam int SCRATCH_TESTS = 24;
  localparam int TIMER_MAX     = 20;
  localparam int NUM_CYCLES    = 14 + 3 * RAM_TESTS + 5 * LINE_TESTS + 2 * SCRATCH_TESTS
                                 + SCRATCH_REGS + 5 + 2 * (TIMER_MAX + 9) + 3;
  localparam int WATCHDOG_NS   = (NUM_CYCLES + 50) * CLK_PERIOD;

  logic clk_i, rst_ni, instr_req_i, instr_gnt_o, instr_rvalid_o;
  logic data_req_i, data_we_i, data_gnt_o, data_rvalid_o;
  logic irq_ack_i, irq_timer_o, tests_passed_o, tests_failed_o, exit_valid_o;
  ram_addr_t    instr_addr_i;
  instr_rdata_t instr_rdata_o;
  data_t        data_addr_i, data_wdata_i, data_rdata_o, exit_value_o;
  be_t          data_be_i;
  irq_id_t      irq_id_i;

  // expected now, expected next cycle, and due in the cycle being checked
  logic exp_data_gnt, exp_instr_gnt, exp_passed, exp_failed, exp_exit_valid, exp_irq;
  data_t exp_exit_value;
  logic nxt_data_rvalid, nxt_data_read, nxt_instr_rvalid;
  logic due_data_rvalid, due_data_read, due_instr_rvalid;
  data_t nxt_data_rdata, due_data_rdata;
  instr_rdata_t nxt_instr_rdata, due_instr_rdata;
  int checks_done;

  task automatic abort_run();
    $display("test failed");
    $fatal(1, "simulation stopped at the first error");
  endtask

`include "tb_mm_ram_model.svh"

  mm_ram dut_i (.*);

  initial begin
    clk_i = 1'b0;
    forever #(CLK_PERIOD / 2) clk_i = ~clk_i;
  end

  task automatic check_outputs();
    check_bit("data_gnt_o", data_gnt_o, exp_data_gnt);
    check_bit("instr_gnt_o", instr_gnt_o, exp_instr_gnt);
    check_bit("tests_passed_o", tests_passed_o, exp_passed);
    check_bit("tests_failed_o", tests_failed_o, exp_failed);
    check_bit("exit_valid_o", exit_valid_o, exp_exit_valid);
    if (exp_exit_valid) check_data("exit_value_o", exit_value_o, exp_exit_value);
    check_bit("irq_timer_o", irq_timer_o, exp_irq);
    check_bit("data_rvalid_o", data_rvalid_o, due_data_rvalid);
    if (due_data_read) check_data("data_rdata_o", data_rdata_o, due_data_rdata);
    check_bit("instr_rvalid_o", instr_rvalid_o, due_instr_rvalid);
    if (due_instr_rvalid) check_line("instr_rdata_o", instr_rdata_o, due_instr_rdata);
    // this cycle's requests are answered in the next one
    due_data_rvalid  = nxt_data_rvalid;
    due_data_read    = nxt_data_read;
    due_data_rdata   = nxt_data_rdata;
    due_instr_rvalid = nxt_instr_rvalid;
    due_instr_rdata  = nxt_instr_rdata;
    checks_done++;
  endtask

  initial begin
    forever begin
      @(negedge clk_i);
      #(CLK_PERIOD / 2 - 1);
      check_outputs();
    end
  end

  // idle inputs and cleared expectations for the next cycle
  task automatic next_cycle();
    @(negedge clk_i);
    {data_req_i, data_we_i, instr_req_i, irq_ack_i} = '0;
    {data_addr_i, data_wdata_i, data_be_i, instr_addr_i, irq_id_i} = '0;
    {exp_data_gnt, exp_instr_gnt, exp_passed, exp_failed, exp_exit_valid} = '0;
    exp_exit_value = '0;
    {nxt_data_rvalid, nxt_data_read, nxt_instr_rvalid} = '0;
    nxt_data_rdata  = '0;
    nxt_instr_rdata = '0;
  endtask

  task automatic data_access(input logic we, input data_t addr, input be_t be, input data_t wdata);
    next_cycle();
    data_req_i      = 1'b1;
    data_we_i       = we;
    data_addr_i     = addr;
    data_be_i       = be;
    data_wdata_i    = wdata;
    exp_data_gnt    = is_mapped(addr, we);
    nxt_data_rvalid = exp_data_gnt;
    nxt_data_read   = exp_data_gnt && !we;
    if (we) begin
      exp_passed     = (addr == ADDR_TEST_STATUS) && (wdata == TEST_PASS_VALUE);
      exp_failed     = (addr == ADDR_TEST_STATUS) && (wdata == TEST_FAIL_VALUE);
      exp_exit_valid = (addr == ADDR_EXIT);
      exp_exit_value = wdata;
      model_write(addr, be, wdata);
    end else begin
      nxt_data_rdata = ref_read(addr);
    end
  endtask

  task automatic instr_fetch(input ram_addr_t addr);
    next_cycle();
    instr_req_i      = 1'b1;
    instr_addr_i     = addr;
    exp_instr_gnt    = 1'b1;
    nxt_instr_rvalid = 1'b1;
    nxt_instr_rdata  = ref_line(addr);
  endtask

  // full words first so that partial writes never leave undefined bytes
  task automatic exercise_ram();
    int unsigned words [$];
    int unsigned w;
    for (int i = 0; i < RAM_TESTS; i++) begin
      w = $urandom_range(32'h1FFF, 0);
      words.push_back(w);
      data_access(1'b1, data_t'(w << 2), 4'hF, data_t'($urandom));
    end
    foreach (words[i]) begin
      data_access(1'b1, data_t'(words[i] << 2), be_t'($urandom), data_t'($urandom));
    end
    foreach (words[i]) data_access(1'b0, data_t'(words[i] << 2), 4'hF, '0);
  endtask

  // lines live in the upper half away from the random words
  task automatic fetch_lines();
    ram_addr_t line;
    for (int i = 0; i < LINE_TESTS; i++) begin
      line = ram_addr_t'($urandom_range(32'hFFF, 32'h800) << 4);
      for (int k = 0; k < 4; k++) begin
        data_access(1'b1, data_t'(line) + data_t'(4 * k), 4'hF, data_t'($urandom));
      end
      instr_fetch(line);
    end
  endtask

  task automatic exercise_scratch();
    for (int i = 0; i < SCRATCH_TESTS; i++) begin
      data_access(1'b1, scratch_addr(4'($urandom_range(15, 0))), be_t'($urandom),
                  data_t'($urandom));
    end
    for (int i = 0; i < SCRATCH_TESTS; i++) begin
      data_access(1'b0, scratch_addr(4'($urandom_range(15, 0))), 4'hF, '0);
    end
    for (int i = 0; i < SCRATCH_REGS; i++) data_access(1'b0, scratch_addr(4'(i)), 4'hF, '0);
  endtask

  task automatic write_status();
    data_access(1'b1, ADDR_TEST_STATUS, 4'hF, TEST_PASS_VALUE);
    data_access(1'b1, ADDR_TEST_STATUS, 4'hF, TEST_FAIL_VALUE);
    data_access(1'b1, ADDR_TEST_STATUS, 4'hF, 32'h0000_0002);
    data_access(1'b1, ADDR_EXIT, 4'hF, data_t'($urandom));
    next_cycle();
  endtask

  task automatic run_timer(input logic enabled);
    int unsigned count;
    count = $urandom_range(TIMER_MAX, 1);
    data_access(1'b1, ADDR_TIMER_MASK, 4'hF, enabled ? data_t'(1 << TIMER_IRQ_ID) : '0);
    data_access(1'b1, ADDR_TIMER_COUNT, 4'hF, data_t'(count));
    // the interrupt rises count edges after the load edge
    repeat (count) next_cycle();
    next_cycle();
    exp_irq = enabled;
    repeat (4) next_cycle();
    if (enabled) begin
      next_cycle();
      irq_ack_i = 1'b1;
      irq_id_i  = irq_id_t'(TIMER_IRQ_ID);
      next_cycle();
      exp_irq = 1'b0;
    end
  endtask

  initial begin
    {data_req_i, data_we_i, instr_req_i, irq_ack_i} = '0;
    {data_addr_i, data_wdata_i, data_be_i, instr_addr_i, irq_id_i} = '0;
    {exp_data_gnt, exp_instr_gnt, exp_passed, exp_failed, exp_exit_valid, exp_irq} = '0;
    {nxt_data_rvalid, nxt_data_read, nxt_instr_rvalid} = '0;
    {due_data_rvalid, due_data_read, due_instr_rvalid} = '0;
    {exp_exit_value, nxt_data_rdata, due_data_rdata} = '0;
    {nxt_instr_rdata, due_instr_rdata} = '0;
    checks_done = 0;
    // scratch registers come out of reset as zero
    foreach (model_scratch[i]) begin
      model_scratch[i] = '0;
    end
    rst_ni = 1'b0;
    void'($urandom(SEED));
    repeat (10) next_cycle();
    rst_ni = 1'b1;
    exercise_ram();
    fetch_lines();
    exercise_scratch();
    write_status();
    run_timer(1'b0);
    run_timer(1'b1);
    repeat (3) next_cycle();
    if (checks_done > NUM_CYCLES / 2) begin
      $display("test passed");
      $finish;
    end else begin
      $display("checker ran only %0d times, outputs were not compared", checks_done);
      abort_run();
    end
  end

  initial begin
    #(WATCHDOG_NS);
    $display("timeout: stimulus still running after %0d ns", WATCHDOG_NS);
    abort_run();
  end

endmodule

`default_nettype wire

// ==== rtl/mm_ram.sv ====
// memory model top for a small RISC-V core testbench
// no back-pressure, grant comes in the request cycle and rvalid one cycle later
// reads from the timer or status block are unmapped and not granted
// data_rdata_o reads zero after a granted write or a non-readable target
`timescale 1ns/1ps
`default_nettype none

module mm_ram
  import mm_pkg::*;
(
  input  logic         clk_i,
  input  logic         rst_ni,

  input  logic         instr_req_i,
  input  ram_addr_t    instr_addr_i,
  output instr_rdata_t instr_rdata_o,
  output logic         instr_rvalid_o,
  output logic         instr_gnt_o,

  input  logic         data_req_i,
  input  data_t        data_addr_i,
  input  logic         data_we_i,
  input  be_t          data_be_i,
  input  data_t        data_wdata_i,
  output data_t        data_rdata_o,
  output logic         data_rvalid_o,
  output logic         data_gnt_o,

  input  irq_id_t      irq_id_i,
  input  logic         irq_ack_i,
  output logic         irq_timer_o,

  output logic         tests_passed_o,
  output logic         tests_failed_o,
  output logic         exit_valid_o,
  output data_t        exit_value_o
);

  target_e target;
  target_e target_q;
  logic    data_gnt;
  logic    ram_req;
  logic    scratch_req;
  logic    timer_mask_we;
  logic    timer_count_we;
  logic    data_rvalid_q;
  logic    instr_rvalid_q;
  data_t   ram_rdata;
  data_t   scratch_rdata;

  mm_addr_decode u_decode (
    .data_req_i       (data_req_i),
    .data_addr_i      (data_addr_i),
    .data_we_i        (data_we_i),
    .data_wdata_i     (data_wdata_i),
    .target_o         (target),
    .gnt_o            (data_gnt),
    .ram_req_o        (ram_req),
    .scratch_req_o    (scratch_req),
    .timer_mask_we_o  (timer_mask_we),
    .timer_count_we_o (timer_count_we),
    .tests_passed_o   (tests_passed_o),
    .tests_failed_o   (tests_failed_o),
    .exit_valid_o     (exit_valid_o),
    .exit_value_o     (exit_value_o)
  );

  mm_dp_ram u_ram (
    .clk_i         (clk_i),
    .instr_req_i   (instr_req_i),
    .instr_addr_i  (instr_addr_i),
    .instr_rdata_o (instr_rdata_o),
    .data_req_i    (ram_req),
    .data_addr_i   (data_addr_i[RAM_ADDR_WIDTH-1:0]),
    .data_we_i     (data_we_i),
    .data_be_i     (data_be_i),
    .data_wdata_i  (data_wdata_i),
    .data_rdata_o  (ram_rdata)
  );

  mm_timer u_timer (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .mask_we_i   (timer_mask_we),
    .count_we_i  (timer_count_we),
    .wdata_i     (data_wdata_i),
    .irq_ack_i   (irq_ack_i),
    .irq_id_i    (irq_id_i),
    .irq_timer_o (irq_timer_o)
  );

  // register index taken from address bits 5 to 2
  mm_scratch_regs u_scratch (
    .clk_i   (clk_i),
    .rst_ni  (rst_ni),
    .req_i   (scratch_req),
    .we_i    (data_we_i),
    .index_i (data_addr_i[5:2]),
    .wdata_i (data_wdata_i),
    .rdata_o (scratch_rdata)
  );

  // target and valids follow the request by one cycle
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      target_q       <= TGT_NONE;
      data_rvalid_q  <= 1'b0;
      instr_rvalid_q <= 1'b0;
    end else begin
      target_q       <= data_we_i ? TGT_NONE : target;
      data_rvalid_q  <= data_gnt;
      instr_rvalid_q <= instr_req_i;
    end
  end

  // read data mux, steered by the target of the previous request
  always_comb begin
    case (target_q)
      TGT_RAM:     data_rdata_o = ram_rdata;
      TGT_SCRATCH: data_rdata_o = scratch_rdata;
      default:     data_rdata_o = '0;
    endcase
  end

  assign instr_gnt_o    = instr_req_i;
  assign instr_rvalid_o = instr_rvalid_q;
  assign data_gnt_o     = data_gnt;
  assign data_rvalid_o  = data_rvalid_q;

endmodule

`default_nettype wire

// ==== rtl/mm_scratch_regs.sv ====
// bank of general purpose scratch registers for test software
// writes land on the edge, reads return one cycle after the request
`timescale 1ns/1ps
`default_nettype none

module mm_scratch_regs
  import mm_pkg::*;
(
  input  logic                            clk_i,
  input  logic                            rst_ni,
  input  logic                            req_i,
  input  logic                            we_i,
  input  logic [$clog2(SCRATCH_REGS)-1:0] index_i,
  input  data_t                           wdata_i,
  output data_t                           rdata_o
);

  data_t regs_q [SCRATCH_REGS];
  data_t rdata_q;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      for (int i = 0; i < SCRATCH_REGS; i++) begin
        regs_q[i] <= '0;
      end
      rdata_q <= '0;
    end else if (req_i) begin
      if (we_i) begin
        regs_q[index_i] <= wdata_i;
      end else begin
        // read result held until the next read
        rdata_q <= regs_q[index_i];
      end
    end
  end

  assign rdata_o = rdata_q;

endmodule

`default_nettype wire

// ==== rtl/mm_timer.sv ====
// countdown timer with a 32-bit interrupt mask
// the counter pauses in any cycle that writes the mask or the count
// the interrupt stays high until acknowledged with TIMER_IRQ_ID
`timescale 1ns/1ps
`default_nettype none

module mm_timer
  import mm_pkg::*;
(
  input  logic    clk_i,
  input  logic    rst_ni,
  input  logic    mask_we_i,
  input  logic    count_we_i,
  input  data_t   wdata_i,
  input  logic    irq_ack_i,
  input  irq_id_t irq_id_i,
  output logic    irq_timer_o
);

  data_t mask_q;
  data_t count_q;
  logic  irq_q;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      mask_q  <= '0;
      count_q <= '0;
      irq_q   <= 1'b0;
    end else begin
      if (mask_we_i) begin
        mask_q <= wdata_i;
      end else if (count_we_i) begin
        count_q <= wdata_i;
      end else if (count_q != '0) begin
        count_q <= count_q - 1'b1;
        // fire on the 1 to 0 step when enabled
        if (count_q == 32'd1 && mask_q[TIMER_IRQ_ID]) begin
          irq_q <= 1'b1;
        end
      end
      // acknowledge wins over a new expiry in the same cycle
      if (irq_ack_i && irq_id_i == irq_id_t'(TIMER_IRQ_ID)) begin
        irq_q <= 1'b0;
      end
    end
  end

  assign irq_timer_o = irq_q;

  // the decoder selects one timer address per request
  timer_single_write : assert property (
    @(posedge clk_i) disable iff (!rst_ni) !(mask_we_i && count_we_i)
  ) else $error("timer mask and count written in the same cycle");

endmodule

`default_nettype wire

// ==== rtl/mm_dp_ram.sv ====
// dual port RAM organized as 32-bit words, contents are not reset
// the instruction port ignores the low four address bits and returns
// the aligned 128-bit line, lowest word in the least significant bits
`timescale 1ns/1ps
`default_nettype none

module mm_dp_ram
  import mm_pkg::*;
(
  input  logic         clk_i,

  input  logic         instr_req_i,
  input  ram_addr_t    instr_addr_i,
  output instr_rdata_t instr_rdata_o,

  input  logic         data_req_i,
  input  ram_addr_t    data_addr_i,
  input  logic         data_we_i,
  input  be_t          data_be_i,
  input  data_t        data_wdata_i,
  output data_t        data_rdata_o
);

  data_t mem [RAM_WORDS];

  logic [RAM_ADDR_WIDTH-3:0] data_word;

  assign data_word = data_addr_i[RAM_ADDR_WIDTH-1:2];

  // data port, byte enabled write or single word read
  always_ff @(posedge clk_i) begin
    if (data_req_i) begin
      if (data_we_i) begin
        for (int b = 0; b < 4; b++) begin
          if (data_be_i[b]) begin
            mem[data_word][8*b +: 8] <= data_wdata_i[8*b +: 8];
          end
        end
      end else begin
        data_rdata_o <= mem[data_word];
      end
    end
  end

  // instruction port reads four consecutive words per request
  always_ff @(posedge clk_i) begin
    if (instr_req_i) begin
      for (int w = 0; w < 4; w++) begin
        instr_rdata_o[32*w +: 32] <= mem[{instr_addr_i[RAM_ADDR_WIDTH-1:4], 2'(w)}];
      end
    end
  end

  // the core only issues word aligned data accesses, sub-word via byte enables
  data_addr_aligned : assert property (
    @(posedge clk_i) data_req_i |-> (data_addr_i[1:0] == 2'b00)
  ) else $error("unaligned data access at %04x", data_addr_i);

endmodule

`default_nettype wire

// ==== rtl/mm_addr_decode.sv ====
// data request decoder, purely combinational
// status and timer addresses accept writes only, reads there are unmapped
// unmapped requests get no grant and are reported by an assertion
`timescale 1ns/1ps
`default_nettype none

module mm_addr_decode
  import mm_pkg::*;
(
  input  logic    data_req_i,
  input  data_t   data_addr_i,
  input  logic    data_we_i,
  input  data_t   data_wdata_i,

  output target_e target_o,
  output logic    gnt_o,
  output logic    ram_req_o,
  output logic    scratch_req_o,
  output logic    timer_mask_we_o,
  output logic    timer_count_we_o,
  output logic    tests_passed_o,
  output logic    tests_failed_o,
  output logic    exit_valid_o,
  output data_t   exit_value_o
);

  logic in_ram;
  logic in_scratch;
  logic is_timer;
  logic is_status;

  // address map compares
  assign in_ram     = (data_addr_i[31:RAM_ADDR_WIDTH] == '0);
  assign in_scratch = (data_addr_i[31:16] == SCRATCH_BASE_HI);
  assign is_timer   = (data_addr_i == ADDR_TIMER_MASK) || (data_addr_i == ADDR_TIMER_COUNT);
  assign is_status  = (data_addr_i == ADDR_TEST_STATUS) || (data_addr_i == ADDR_EXIT);

  always_comb begin
    target_o = TGT_NONE;
    if (data_req_i) begin
      if (in_ram) begin
        target_o = TGT_RAM;
      end else if (in_scratch) begin
        target_o = TGT_SCRATCH;
      end else if (data_we_i && is_timer) begin
        target_o = TGT_TIMER;
      end else if (data_we_i && is_status) begin
        target_o = TGT_STATUS;
      end
    end
  end

  assign gnt_o         = (target_o != TGT_NONE);
  assign ram_req_o     = (target_o == TGT_RAM);
  assign scratch_req_o = (target_o == TGT_SCRATCH);

  // single cycle timer write strobes
  assign timer_mask_we_o  = (target_o == TGT_TIMER) && (data_addr_i == ADDR_TIMER_MASK);
  assign timer_count_we_o = (target_o == TGT_TIMER) && (data_addr_i == ADDR_TIMER_COUNT);

  // status pulses last only for the granted write
  assign tests_passed_o = (target_o == TGT_STATUS) && (data_addr_i == ADDR_TEST_STATUS)
                          && (data_wdata_i == TEST_PASS_VALUE);
  assign tests_failed_o = (target_o == TGT_STATUS) && (data_addr_i == ADDR_TEST_STATUS)
                          && (data_wdata_i == TEST_FAIL_VALUE);
  assign exit_valid_o   = (target_o == TGT_STATUS) && (data_addr_i == ADDR_EXIT);
  assign exit_value_o   = exit_valid_o ? data_wdata_i : '0;

  // a request outside the map is a core or program bug
  always_comb begin
    if (data_req_i) begin
      unmapped_request : assert final (target_o != TGT_NONE)
        else $error("unmapped %s at %08x", data_we_i ? "write" : "read", data_addr_i);
    end
  end

endmodule

`default_nettype wire

// ==== rtl/mm_pkg.sv ====
// shared widths, address map and magic values of the memory model
// all widths are fixed here, the modules carry no parameters
// the RAM sits at address zero and spans 2**RAM_ADDR_WIDTH bytes
`default_nettype none

package mm_pkg;

  // RAM geometry
  localparam int RAM_ADDR_WIDTH    = 16;
  localparam int RAM_WORDS         = 2 ** (RAM_ADDR_WIDTH - 2);
  localparam int INSTR_RDATA_WIDTH = 128;

  typedef logic [31:0]                  data_t;
  typedef logic [3:0]                   be_t;
  typedef logic [RAM_ADDR_WIDTH-1:0]    ram_addr_t;
  typedef logic [INSTR_RDATA_WIDTH-1:0] instr_rdata_t;
  typedef logic [4:0]                   irq_id_t;

  // test status block
  localparam data_t ADDR_TEST_STATUS = 32'h2000_0000;
  localparam data_t ADDR_EXIT        = 32'h2000_0004;

  // countdown timer
  localparam data_t ADDR_TIMER_MASK  = 32'h1500_0000;
  localparam data_t ADDR_TIMER_COUNT = 32'h1500_0004;

  // scratch bank, selected by the upper half of the address
  localparam logic [15:0] SCRATCH_BASE_HI = 16'h1600;

  localparam data_t TEST_PASS_VALUE = 32'd123456789;
  localparam data_t TEST_FAIL_VALUE = 32'd1;

  // mask bit and acknowledge id of the timer interrupt
  localparam int TIMER_IRQ_ID = 7;

  localparam int SCRATCH_REGS = 16;

  typedef enum logic [2:0] {
    TGT_NONE    = 3'd0,
    TGT_RAM     = 3'd1,
    TGT_SCRATCH = 3'd2,
    TGT_TIMER   = 3'd3,
    TGT_STATUS  = 3'd4
  } target_e;

endpackage

`default_nettype wire
